/* files.f */
hdl/mem_pkg.sv
hdl/dcache_if.sv
hdl/dcache.sv
hdl/mem_stage.sv
hdl/tagged_memory.sv
hdl/mem_subsystem.sv
verification/mem_subsystem_tb.sv

/* hdl/dcache.sv */
// Direct-mapped write-through data cache with a single outstanding load miss
`timescale 1ns/10ps

module dcache import mem_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,

    // Request from the memory stage
    dcache_if.cache                 cache_bus,

    // Command side of the memory bus
    output bus_command_t            mem_command,
    output logic [ADDR_BITS-1:0]    mem_addr,
    output logic [63:0]             mem_store_data,

    // Response side of the memory bus
    input  logic [MEM_TAG_BITS-1:0] mem_response,
    input  logic [63:0]             mem_load_data,
    input  logic [MEM_TAG_BITS-1:0] mem_data_tag
);

    ////////////////////
    // Line storage
    ////////////////////

    // Line contents and tags with one valid bit per line
    logic [63:0]         line_data  [CACHE_LINES];
    logic [TAG_BITS-1:0] line_tag   [CACHE_LINES];
    logic [CACHE_LINES-1:0] line_valid;

    // Address split into tag and index above the offset
    logic [TAG_BITS-1:0]   req_tag;
    logic [INDEX_BITS-1:0] req_index;

    assign {req_tag, req_index} = cache_bus.addr[ADDR_BITS-1:OFFSET_BITS];

    // Hit check against the indexed line
    logic line_hit;

    assign line_hit = line_valid[req_index] && (line_tag[req_index] == req_tag);

    ////////////////////
    // Miss tracking
    ////////////////////

    // Set once memory has accepted the load and cleared by the fill
    logic                    miss_pending;
    // Response tag memory gave for the outstanding load
    logic [MEM_TAG_BITS-1:0] miss_tag;

    logic load_miss;
    logic store_accepted;
    logic load_accepted;
    logic fill;

    assign load_miss = (cache_bus.command == BUS_LOAD) && !line_hit;

    // Memory takes a command when it answers with a nonzero tag
    assign store_accepted = (mem_command == BUS_STORE) && (mem_response != '0);
    assign load_accepted  = (mem_command == BUS_LOAD) && (mem_response != '0);

    // Data beat for our load
    assign fill = miss_pending && (mem_data_tag == miss_tag);

    // Command stays on the bus until memory takes it
    always_comb begin
        mem_command = BUS_NONE;
        if (cache_bus.command == BUS_STORE) begin
            mem_command = BUS_STORE;
        end else if (load_miss && !miss_pending) begin
            mem_command = BUS_LOAD;
        end
    end

    // Memory works on whole doublewords
    assign mem_addr       = {cache_bus.addr[ADDR_BITS-1:OFFSET_BITS], OFFSET_BITS'(0)};
    assign mem_store_data = cache_bus.store_data;

    // A filled miss shows up as a hit one cycle later
    assign cache_bus.access_done = ((cache_bus.command == BUS_LOAD) && line_hit)
                                   || store_accepted;
    assign cache_bus.load_data   = line_data[req_index];

    always_ff @(posedge clock) begin
        if (reset) begin
            miss_pending <= 1'b0;
            miss_tag     <= '0;
        end else if (load_accepted) begin
            miss_pending <= 1'b1;
            miss_tag     <= mem_response;
        end else if (fill) begin
            miss_pending <= 1'b0;
            miss_tag     <= '0;
        end
    end

    ////////////////////
    // Line updates
    ////////////////////

    // Valid bits
    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (store_accepted || fill) begin
            line_valid[req_index] <= 1'b1;
        end
    end

    // Store allocates the line and fill brings it in from memory
    always_ff @(posedge clock) begin
        if (store_accepted || fill) begin
            line_tag[req_index] <= req_tag;
        end
        if (store_accepted) begin
            line_data[req_index] <= cache_bus.store_data;
        end else if (fill) begin
            line_data[req_index] <= mem_load_data;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Bus goes quiet once the store is taken or the miss is filled
    a_bus_quiet: assert property (@(posedge clock) disable iff (reset)
        (store_accepted || fill) |=> (mem_command == BUS_NONE))
        else $error("dcache: memory command after the access was served");

    // Kept tag is never 0 and any beat during the miss carries it
    a_miss_tag: assert property (@(posedge clock) disable iff (reset)
        miss_pending |-> ((miss_tag != '0)
                          && ((mem_data_tag == '0) || (mem_data_tag == miss_tag))))
        else $error("dcache: kept response tag is zero or a foreign beat arrived");

endmodule

/* hdl/dcache_if.sv */
// Request and response bundle between the memory stage and the data cache
`timescale 1ns/10ps

interface dcache_if import mem_pkg::*; ();

    // Stage to cache, held steady while a request is open
    bus_command_t         command;
    logic [ADDR_BITS-1:0] addr;
    logic [63:0]          store_data;

    // Cache to stage
    logic [63:0]          load_data;
    // High in the cycle the open request completes
    logic                 access_done;

    // Memory stage side
    modport stage (
        output command,
        output addr,
        output store_data,
        input  load_data,
        input  access_done
    );

    // Cache side
    modport cache (
        input  command,
        input  addr,
        input  store_data,
        output load_data,
        output access_done
    );

endinterface

/* hdl/mem_pkg.sv */
// Shared types and constants for the data memory subsystem
package mem_pkg;

    ////////////////////
    // Memory bus
    ////////////////////

    // Command on the memory bus and on the cache interface
    typedef enum logic [1:0] {
        BUS_NONE  = 2'b00,
        BUS_LOAD  = 2'b01,
        BUS_STORE = 2'b10
    } bus_command_t;

    // Byte address space of the data side
    localparam int ADDR_BITS = 16;

    // Byte within a doubleword, ignored by cache and memory
    localparam int OFFSET_BITS = 3;

    ////////////////////
    // Data cache
    ////////////////////

    // Direct mapped, one doubleword per line
    localparam int CACHE_LINES = 32;
    localparam int INDEX_BITS  = $clog2(CACHE_LINES);

    // Whatever is left of the address above index and offset
    localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

    ////////////////////
    // Main memory
    ////////////////////

    // Response tag width, zero means no response
    localparam int MEM_TAG_BITS = 4;

    // Doublewords in main memory, covers the whole address space
    localparam int MEM_WORDS = 8192;

    // Cycles from command acceptance to the data beat
    localparam int MEM_LATENCY = 6;

    ////////////////////
    // Memory stage
    ////////////////////

    // Idle, waiting on the cache, reporting completion
    typedef enum logic [1:0] {
        STAGE_IDLE = 2'b00,
        STAGE_WAIT = 2'b01,
        STAGE_DONE = 2'b10
    } stage_state_t;

endpackage

/* hdl/mem_stage.sv */
// Memory pipeline stage holding one load or store until the cache finishes it
`timescale 1ns/10ps

module mem_stage import mem_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,

    // Request from the pipeline
    input  logic                 req_valid,
    input  logic                 req_store,
    input  logic [ADDR_BITS-1:0] req_addr,
    input  logic [63:0]          req_data,

    // Back to the pipeline
    output logic                 stall,
    output logic                 done,
    output logic [63:0]          load_data,

    // To the data cache
    dcache_if.stage              cache_bus
);

    ////////////////////
    // Request capture
    ////////////////////

    stage_state_t         state;
    bus_command_t         held_command;
    logic [ADDR_BITS-1:0] held_addr;
    logic [63:0]          held_data;
    logic [63:0]          held_load_data;
    logic                 take;

    // Busy from the cycle after capture until done has been shown
    assign stall = (state != STAGE_IDLE);
    assign take  = req_valid && !stall;

    // Payload, no reset needed
    always_ff @(posedge clock) begin
        if (take) begin
            held_command <= req_store ? BUS_STORE : BUS_LOAD;
            held_addr    <= req_addr;
            held_data    <= req_data;
        end
        // Keep what the cache returns as the access completes
        if ((state == STAGE_WAIT) && cache_bus.access_done) begin
            held_load_data <= cache_bus.load_data;
        end
    end

    ////////////////////
    // Stage FSM
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= STAGE_IDLE;
        end else begin
            case (state)
                STAGE_IDLE: begin
                    if (take) begin
                        state <= STAGE_WAIT;
                    end
                end
                STAGE_WAIT: begin
                    if (cache_bus.access_done) begin
                        state <= STAGE_DONE;
                    end
                end
                default: begin
                    state <= STAGE_IDLE;
                end
            endcase
        end
    end

    // Command only while waiting, so it drops right after access_done
    assign cache_bus.command    = (state == STAGE_WAIT) ? held_command : BUS_NONE;
    assign cache_bus.addr       = held_addr;
    assign cache_bus.store_data = held_data;

    // One cycle pulse, data valid alongside it
    assign done      = (state == STAGE_DONE);
    assign load_data = held_load_data;

    // done only follows a completed access, never an idle cycle
    a_done_after_access: assert property (@(posedge clock) disable iff (reset)
        done |-> ($past(state) == STAGE_WAIT) && $past(cache_bus.access_done))
        else $error("mem_stage: done without a completed cache access");

endmodule

/* hdl/mem_subsystem.sv */
// Data memory subsystem tying the memory stage, data cache and main memory together
`timescale 1ns/10ps

module mem_subsystem import mem_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,

    // Pipeline request
    input  logic                 req_valid,
    input  logic                 req_store,
    input  logic [ADDR_BITS-1:0] req_addr,
    input  logic [63:0]          req_data,

    // Pipeline response
    output logic                 stall,
    output logic                 done,
    output logic [63:0]          load_data
);

    // Stage to cache
    dcache_if cache_bus ();

    // Memory bus between cache and main memory
    bus_command_t            mem_command;
    logic [ADDR_BITS-1:0]    mem_addr;
    logic [63:0]             mem_store_data;
    logic [MEM_TAG_BITS-1:0] mem_response;
    logic [63:0]             mem_load_data;
    logic [MEM_TAG_BITS-1:0] mem_data_tag;

    mem_stage u_mem_stage (
        .clock     (clock),
        .reset     (reset),
        .req_valid (req_valid),
        .req_store (req_store),
        .req_addr  (req_addr),
        .req_data  (req_data),
        .stall     (stall),
        .done      (done),
        .load_data (load_data),
        .cache_bus (cache_bus.stage)
    );

    dcache u_dcache (
        .clock          (clock),
        .reset          (reset),
        .cache_bus      (cache_bus.cache),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .mem_store_data (mem_store_data),
        .mem_response   (mem_response),
        .mem_load_data  (mem_load_data),
        .mem_data_tag   (mem_data_tag)
    );

    tagged_memory u_tagged_memory (
        .clock          (clock),
        .reset          (reset),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .mem_store_data (mem_store_data),
        .mem_response   (mem_response),
        .mem_load_data  (mem_load_data),
        .mem_data_tag   (mem_data_tag)
    );

endmodule

/* hdl/tagged_memory.sv */
// Main memory model with response tags, one-cycle refusal and fixed load latency
`timescale 1ns/10ps

module tagged_memory import mem_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,

    // Commands from the cache
    input  bus_command_t            mem_command,
    input  logic [ADDR_BITS-1:0]    mem_addr,
    input  logic [63:0]             mem_store_data,

    // Responses to the cache
    output logic [MEM_TAG_BITS-1:0] mem_response,
    output logic [63:0]             mem_load_data,
    output logic [MEM_TAG_BITS-1:0] mem_data_tag
);

    ////////////////////
    // Storage
    ////////////////////

    logic [63:0] mem_array [MEM_WORDS];

    // Doubleword index, offset bits ignored
    logic [ADDR_BITS-OFFSET_BITS-1:0] word_index;

    assign word_index = mem_addr[ADDR_BITS-1:OFFSET_BITS];

    ////////////////////
    // Acceptance
    ////////////////////

    // Next tag to hand out, cycles through 1..15
    logic [MEM_TAG_BITS-1:0] tag_counter;
    // Memory was busy accepting last cycle
    logic                    accepted_last;
    logic                    accept;

    assign accept       = (mem_command != BUS_NONE) && !accepted_last;
    // Zero response means refused, cache retries
    assign mem_response = accept ? tag_counter : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            tag_counter   <= MEM_TAG_BITS'(1);
            accepted_last <= 1'b0;
        end else begin
            accepted_last <= accept;
            if (accept) begin
                // Skip 0 on wrap
                tag_counter <= (tag_counter == '1) ? MEM_TAG_BITS'(1) : tag_counter + 1'b1;
            end
        end
    end

    // Reset loads the contents rule, accepted stores write afterwards
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < MEM_WORDS; k++) begin
                mem_array[k] <= {4{16'(k) ^ 16'h5a00}};
            end
        end else if (accept && (mem_command == BUS_STORE)) begin
            mem_array[word_index] <= mem_store_data;
        end
    end

    ////////////////////
    // Load return pipe
    ////////////////////

    // Slot k holds a load accepted k+1 cycles ago
    logic [MEM_TAG_BITS-1:0] pipe_tag  [MEM_LATENCY];
    logic [63:0]             pipe_data [MEM_LATENCY];

    // Tags need reset so the bus idles at 0
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < MEM_LATENCY; k++) begin
                pipe_tag[k] <= '0;
            end
        end else begin
            pipe_tag[0] <= (accept && (mem_command == BUS_LOAD)) ? tag_counter : '0;
            for (int k = 1; k < MEM_LATENCY; k++) begin
                pipe_tag[k] <= pipe_tag[k-1];
            end
        end
    end

    // Data read at acceptance and carried alongside the tag
    always_ff @(posedge clock) begin
        pipe_data[0] <= mem_array[word_index];
        for (int k = 1; k < MEM_LATENCY; k++) begin
            pipe_data[k] <= pipe_data[k-1];
        end
    end

    assign mem_data_tag  = pipe_tag[MEM_LATENCY-1];
    assign mem_load_data = pipe_data[MEM_LATENCY-1];

    // Every accepted command gets a real tag
    a_tag_nonzero: assert property (@(posedge clock) disable iff (reset)
        accept |-> (mem_response != '0))
        else $error("tagged_memory: issued response tag 0");

    // A data beat always traces back to a load accepted MEM_LATENCY cycles earlier
    a_beat_has_load: assert property (@(posedge clock) disable iff (reset)
        (mem_data_tag != '0) |-> $past(accept && (mem_command == BUS_LOAD), MEM_LATENCY))
        else $error("tagged_memory: data beat without a matching load");

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the data memory testbench with Verilator, then scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mem_subsystem_tb \
    -f files.f \
    -o sim_mem_subsystem

./obj_dir/sim_mem_subsystem | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"

/* verification/mem_subsystem_tb.sv */
// Testbench for the data memory subsystem with shadow memory, cache model and timing checks
`timescale 1ns/10ps

module mem_subsystem_tb import mem_pkg::*; ();

    ////////////////////
    // Run limits
    ////////////////////

    // Requests over all tests as 8 + 8 + 4 + 16 + 200
    localparam int REQUEST_COUNT  = 236;
    localparam int RANDOM_COUNT   = 200;
    localparam int TIMEOUT_CYCLES = 40 * REQUEST_COUNT + 100;

    logic                 clock;
    logic                 reset;
    logic                 req_valid;
    logic                 req_store;
    logic [ADDR_BITS-1:0] req_addr;
    logic [63:0]          req_data;
    logic                 stall;
    logic                 done;
    logic [63:0]          load_data;

    mem_subsystem u_mem_subsystem (
        .clock     (clock),
        .reset     (reset),
        .req_valid (req_valid),
        .req_store (req_store),
        .req_addr  (req_addr),
        .req_data  (req_data),
        .stall     (stall),
        .done      (done),
        .load_data (load_data)
    );

    // 4 ns period
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    ////////////////////
    // Bookkeeping
    ////////////////////

    int          cycle_count;
    int          take_cycle;
    int          error_count;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] lfsr_state;

    // Expectations for the open access
    logic        access_open;
    logic        quiet_check;
    logic        cur_load;
    logic        cur_hit;
    logic [63:0] exp_data;

    // Shadow memory holds only written doublewords
    logic [63:0]            shadow [logic [ADDR_BITS-OFFSET_BITS-1:0]];
    // Tag and valid per cache line
    logic [CACHE_LINES-1:0] model_valid;
    logic [TAG_BITS-1:0]    model_tag [CACHE_LINES];

    // Cycle of the edge that took the current request
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (req_valid && !stall) begin
            take_cycle <= cycle_count;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    // Doubleword k holds k xored with 5a00 in every halfword
    function automatic logic [63:0] initial_word(input logic [ADDR_BITS-OFFSET_BITS-1:0] word);
        logic [15:0] half;
        half = 16'(word) ^ 16'h5a00;
        return {half, half, half, half};
    endfunction

    function automatic logic [63:0] shadow_read(input logic [ADDR_BITS-1:0] addr);
        logic [ADDR_BITS-OFFSET_BITS-1:0] word;
        logic [63:0]                      value;
        word = addr[ADDR_BITS-1:OFFSET_BITS];
        if (shadow.exists(word)) begin
            value = shadow[word];
        end else begin
            value = initial_word(word);
        end
        return value;
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [63:0] random_bits(input int count);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[62:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [ADDR_BITS-1:0] make_addr(input logic [TAG_BITS-1:0] tag,
                                                       input logic [INDEX_BITS-1:0] index,
                                                       input logic [OFFSET_BITS-1:0] offset);
        return {tag, index, offset};
    endfunction

    ////////////////////
    // Checks
    ////////////////////

    a_quiet: assert property (@(posedge clock) disable iff (reset)
        quiet_check |-> (!stall && !done))
        else begin
            error_count = error_count + 1;
            $display("stall or done went high with no request pending");
        end

    a_load_data: assert property (@(posedge clock) disable iff (reset)
        (done && cur_load) |-> (load_data == exp_data))
        else begin
            error_count = error_count + 1;
            $display("MISMATCH load_data: got %h expected %h",
                     $sampled(load_data), $sampled(exp_data));
        end

    // Hit is exactly two cycles from take to done
    a_hit_time: assert property (@(posedge clock) disable iff (reset)
        (done && cur_load && cur_hit) |-> ((cycle_count - take_cycle) == 2))
        else begin
            error_count = error_count + 1;
            $display("load hit finished after %0d cycles instead of 2",
                     $sampled(cycle_count) - $sampled(take_cycle));
        end

    a_miss_time: assert property (@(posedge clock) disable iff (reset)
        (done && cur_load && !cur_hit) |-> ((cycle_count - take_cycle) >= MEM_LATENCY + 2))
        else begin
            error_count = error_count + 1;
            $display("load miss finished too early, after %0d cycles",
                     $sampled(cycle_count) - $sampled(take_cycle));
        end

    // Memory is free whenever a store reaches it
    a_store_time: assert property (@(posedge clock) disable iff (reset)
        (done && !cur_load) |-> ((cycle_count - take_cycle) == 2))
        else begin
            error_count = error_count + 1;
            $display("store finished after %0d cycles instead of 2",
                     $sampled(cycle_count) - $sampled(take_cycle));
        end

    a_done_open: assert property (@(posedge clock) disable iff (reset)
        done |-> access_open)
        else begin
            error_count = error_count + 1;
            $display("done pulsed with no access open");
        end

    ////////////////////
    // Stimulus
    ////////////////////

    // Starts and ends 1 ns after an edge with the stage idle
    task automatic run_access(input logic store, input logic [ADDR_BITS-1:0] addr,
                              input logic [63:0] data);
        logic [TAG_BITS-1:0]   tag;
        logic [INDEX_BITS-1:0] index;
        tag   = addr[ADDR_BITS-1:OFFSET_BITS+INDEX_BITS];
        index = addr[OFFSET_BITS+INDEX_BITS-1:OFFSET_BITS];
        // Predict before the models move on
        cur_load    = !store;
        cur_hit     = model_valid[index] && (model_tag[index] == tag);
        exp_data    = store ? data : shadow_read(addr);
        access_open = 1'b1;
        req_valid   = 1'b1;
        req_store   = store;
        req_addr    = addr;
        req_data    = data;
        if (store) begin
            shadow[addr[ADDR_BITS-1:OFFSET_BITS]] = data;
        end
        // Store allocates and miss fills the line
        model_valid[index] = 1'b1;
        model_tag[index]   = tag;
        // Taken on this edge
        @(posedge clock);
        #1;
        req_valid = 1'b0;
        while (!done) begin
            @(posedge clock);
            #1;
        end
        // done sampled here
        @(posedge clock);
        #1;
        access_open = 1'b0;
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed = tests_passed + 1;
            $display("test %s: ok", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    initial begin
        int                   errors_before;
        logic                 store;
        logic [63:0]          data;
        logic [63:0]          pick_tag;
        logic [63:0]          pick_index;
        logic [63:0]          pick_offset;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_store    = 1'b0;
        req_addr     = '0;
        req_data     = '0;
        take_cycle   = 0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        lfsr_state   = 32'ha382_3248;
        access_open  = 1'b0;
        quiet_check  = 1'b0;
        cur_load     = 1'b0;
        cur_hit      = 1'b0;
        exp_data     = '0;
        model_valid  = '0;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;

        // Quiet after reset
        errors_before = error_count;
        quiet_check   = 1'b1;
        repeat (20) begin
            @(posedge clock);
            #1;
        end
        quiet_check = 1'b0;
        report_test("idle after reset", errors_before);

        // Cold loads with one per line
        errors_before = error_count;
        for (int i = 0; i < 8; i++) begin
            run_access(1'b0, make_addr(8'h20 + 8'(i), 5'(i), 3'd0), 64'h0);
        end
        report_test("cold loads", errors_before);

        // Same doublewords again with varied offsets
        errors_before = error_count;
        for (int i = 0; i < 8; i++) begin
            run_access(1'b0, make_addr(8'h20 + 8'(i), 5'(i), 3'(7 - i)), 64'h0);
        end
        report_test("repeat load hits", errors_before);

        // Store and hit, then evict by conflict and reload from memory
        errors_before = error_count;
        data = random_bits(64);
        run_access(1'b1, make_addr(8'h30, 5'd10, 3'd0), data);
        run_access(1'b0, make_addr(8'h30, 5'd10, 3'd0), 64'h0);
        run_access(1'b0, make_addr(8'h31, 5'd10, 3'd0), 64'h0);
        run_access(1'b0, make_addr(8'h30, 5'd10, 3'd0), 64'h0);
        report_test("write-through", errors_before);

        // Back-to-back stores then read all back
        errors_before = error_count;
        for (int i = 0; i < 8; i++) begin
            data = random_bits(64);
            run_access(1'b1, make_addr(8'h50, 5'(16 + i), 3'd0), data);
        end
        for (int i = 0; i < 8; i++) begin
            run_access(1'b0, make_addr(8'h50, 5'(16 + i), 3'd0), 64'h0);
        end
        report_test("back-to-back stores", errors_before);

        // Four tags over four lines keeps conflicts frequent
        errors_before = error_count;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            store       = (random_bits(1) != 64'h0);
            pick_tag    = random_bits(2);
            pick_index  = random_bits(2);
            pick_offset = random_bits(3);
            data        = store ? random_bits(64) : 64'h0;
            run_access(store, make_addr(8'h40 | pick_tag[7:0], pick_index[4:0],
                                        pick_offset[2:0]), data);
        end
        report_test("random mix", errors_before);

        $display("tests ok: %0d, tests with errors: %0d, check errors: %0d",
                 tests_passed, tests_failed, error_count);
        if ((tests_failed == 0) && (error_count == 0)) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Run limit
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule
